//--- Makefile
SRCS := $(wildcard hdl/*.sv testbench/*.sv)

obj_dir/Vtb_issue_unit: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_issue_unit

run: obj_dir/Vtb_issue_unit
	./obj_dir/Vtb_issue_unit

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- hdl/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic [1:0]                        head_v_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rd_h0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs1_h0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs2_h0_i,
  input  logic [issue_pkg::CLS_W-1:0]       cls_h0_i,
  input  logic                              we_h0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rd_h1_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs1_h1_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs2_h1_i,
  input  logic [issue_pkg::CLS_W-1:0]       cls_h1_i,
  input  logic                              we_h1_i,
  input  logic                              stall_m0_i,
  input  logic                              stall_m1_i,
  input  logic                              stall_i,
  input  logic                              flush_i,
  output logic [1:0]                        pop_o,
  output logic                              issue_m0_o,
  output logic                              issue_m1_o,
  output logic [1:0]                        issue_v_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rd_m0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs1_m0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs2_m0_o,
  output logic [issue_pkg::CLS_W-1:0]       cls_m0_o,
  output logic                              we_m0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rd_m1_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs1_m1_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs2_m1_o,
  output logic [issue_pkg::CLS_W-1:0]       cls_m1_o,
  output logic                              we_m1_o,
  output logic [issue_pkg::CNT_W-1:0]       count_instr_o
);

  logic       grant0;
  logic       grant1;
  logic       no_data_conflict;
  logic       no_ex_conflict;
  logic       not_branch0;
  logic       pair_ok;
  logic [1:0] n_grant;

  // second op must not read or rewrite what the first one writes
  assign no_data_conflict = (rs1_h1_i != rd_h0_i && rs2_h1_i != rd_h0_i &&
                             rd_h1_i != rd_h0_i) || !(we_h0_i && rd_h0_i != '0);

  // one unit per class, except the two alus
  assign no_ex_conflict = (cls_h0_i != cls_h1_i) ||
                          (cls_h0_i == issue_pkg::CLS_ALU);

  assign not_branch0 = (cls_h0_i != issue_pkg::CLS_BRANCH);
  assign pair_ok     = no_data_conflict && no_ex_conflict && not_branch0;

  assign grant0 = head_v_i[0] && !stall_m0_i && !stall_i && !flush_i;
  assign grant1 = grant0 && head_v_i[1] && !stall_m1_i && pair_ok;

  assign pop_o      = {grant1, grant0};
  assign issue_m0_o = grant0;
  assign issue_m1_o = grant1;
  assign n_grant    = {1'b0, grant0} + {1'b0, grant1};

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      issue_v_o     <= '0;
      count_instr_o <= '0;
    end else begin
      issue_v_o     <= {grant1, grant0};
      count_instr_o <= count_instr_o + {{(issue_pkg::CNT_W-2){1'b0}}, n_grant};
    end
  end

  // payload follows the grant
  always_ff @(posedge clk) begin
    if (grant0) begin
      rd_m0_o  <= rd_h0_i;
      rs1_m0_o <= rs1_h0_i;
      rs2_m0_o <= rs2_h0_i;
      cls_m0_o <= cls_h0_i;
      we_m0_o  <= we_h0_i;
    end
    if (grant1) begin
      rd_m1_o  <= rd_h1_i;
      rs1_m1_o <= rs1_h1_i;
      rs2_m1_o <= rs2_h1_i;
      cls_m1_o <= cls_h1_i;
      we_m1_o  <= we_h1_i;
    end
  end

endmodule

//--- hdl/issue_pkg.sv
package issue_pkg;

  // register file
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  // micro-op queue
  localparam int IQ_DEPTH  = 8;
  localparam int IQ_PTR_W  = 3;

  // micro-op class, one execution resource each
  localparam int CLS_W     = 2;

  localparam logic [CLS_W-1:0] CLS_ALU    = 2'd0;
  localparam logic [CLS_W-1:0] CLS_MEM    = 2'd1;
  localparam logic [CLS_W-1:0] CLS_MULDIV = 2'd2;
  localparam logic [CLS_W-1:0] CLS_BRANCH = 2'd3;

  // issued instruction counter
  localparam int CNT_W     = 64;

endpackage

//--- hdl/issue_unit.sv
`timescale 1ns/100ps

module issue_unit (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic [1:0]                        fetch_v_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rd_m0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs1_m0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs2_m0_i,
  input  logic [issue_pkg::CLS_W-1:0]       cls_m0_i,
  input  logic                              we_m0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rd_m1_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs1_m1_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs2_m1_i,
  input  logic [issue_pkg::CLS_W-1:0]       cls_m1_i,
  input  logic                              we_m1_i,
  output logic                              fetch_rdy_o,
  output logic [1:0]                        issue_v_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rd_m0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs1_m0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs2_m0_o,
  output logic [issue_pkg::CLS_W-1:0]       cls_m0_o,
  output logic                              we_m0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rd_m1_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs1_m1_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs2_m1_o,
  output logic [issue_pkg::CLS_W-1:0]       cls_m1_o,
  output logic                              we_m1_o,
  input  logic                              wb0_we_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   wb0_rd_i,
  input  logic                              wb1_we_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   wb1_rd_i,
  input  logic                              mu_done_i,
  input  logic                              stall_i,
  input  logic                              flush_i,
  output logic [issue_pkg::CNT_W-1:0]       count_instr_o
);

  logic [1:0]                      head_v;
  logic [issue_pkg::REG_IDX_W-1:0] rd_h0;
  logic [issue_pkg::REG_IDX_W-1:0] rs1_h0;
  logic [issue_pkg::REG_IDX_W-1:0] rs2_h0;
  logic [issue_pkg::CLS_W-1:0]     cls_h0;
  logic                            we_h0;
  logic [issue_pkg::REG_IDX_W-1:0] rd_h1;
  logic [issue_pkg::REG_IDX_W-1:0] rs1_h1;
  logic [issue_pkg::REG_IDX_W-1:0] rs2_h1;
  logic [issue_pkg::CLS_W-1:0]     cls_h1;
  logic                            we_h1;
  logic                            stall_m0;
  logic                            stall_m1;
  logic [1:0]                      pop;
  logic                            issue_m0;
  logic                            issue_m1;

  uop_queue uop_queue_i (
    .clk         (clk),
    .resetn      (resetn),
    .fetch_v_i   (fetch_v_i),
    .rd_m0_i     (rd_m0_i),
    .rs1_m0_i    (rs1_m0_i),
    .rs2_m0_i    (rs2_m0_i),
    .cls_m0_i    (cls_m0_i),
    .we_m0_i     (we_m0_i),
    .rd_m1_i     (rd_m1_i),
    .rs1_m1_i    (rs1_m1_i),
    .rs2_m1_i    (rs2_m1_i),
    .cls_m1_i    (cls_m1_i),
    .we_m1_i     (we_m1_i),
    .pop_i       (pop),
    .flush_i     (flush_i),
    .fetch_rdy_o (fetch_rdy_o),
    .head_v_o    (head_v),
    .rd_h0_o     (rd_h0),
    .rs1_h0_o    (rs1_h0),
    .rs2_h0_o    (rs2_h0),
    .cls_h0_o    (cls_h0),
    .we_h0_o     (we_h0),
    .rd_h1_o     (rd_h1),
    .rs1_h1_o    (rs1_h1),
    .rs2_h1_o    (rs2_h1),
    .cls_h1_o    (cls_h1),
    .we_h1_o     (we_h1)
  );

  reg_scoreboard reg_scoreboard_i (
    .clk        (clk),
    .resetn     (resetn),
    .rd_h0_i    (rd_h0),
    .rs1_h0_i   (rs1_h0),
    .rs2_h0_i   (rs2_h0),
    .cls_h0_i   (cls_h0),
    .we_h0_i    (we_h0),
    .rd_h1_i    (rd_h1),
    .rs1_h1_i   (rs1_h1),
    .rs2_h1_i   (rs2_h1),
    .cls_h1_i   (cls_h1),
    .we_h1_i    (we_h1),
    .issue_m0_i (issue_m0),
    .issue_m1_i (issue_m1),
    .wb0_we_i   (wb0_we_i),
    .wb0_rd_i   (wb0_rd_i),
    .wb1_we_i   (wb1_we_i),
    .wb1_rd_i   (wb1_rd_i),
    .mu_done_i  (mu_done_i),
    .stall_m0_o (stall_m0),
    .stall_m1_o (stall_m1)
  );

  issue_ctrl issue_ctrl_i (
    .clk           (clk),
    .resetn        (resetn),
    .head_v_i      (head_v),
    .rd_h0_i       (rd_h0),
    .rs1_h0_i      (rs1_h0),
    .rs2_h0_i      (rs2_h0),
    .cls_h0_i      (cls_h0),
    .we_h0_i       (we_h0),
    .rd_h1_i       (rd_h1),
    .rs1_h1_i      (rs1_h1),
    .rs2_h1_i      (rs2_h1),
    .cls_h1_i      (cls_h1),
    .we_h1_i       (we_h1),
    .stall_m0_i    (stall_m0),
    .stall_m1_i    (stall_m1),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .pop_o         (pop),
    .issue_m0_o    (issue_m0),
    .issue_m1_o    (issue_m1),
    .issue_v_o     (issue_v_o),
    .rd_m0_o       (rd_m0_o),
    .rs1_m0_o      (rs1_m0_o),
    .rs2_m0_o      (rs2_m0_o),
    .cls_m0_o      (cls_m0_o),
    .we_m0_o       (we_m0_o),
    .rd_m1_o       (rd_m1_o),
    .rs1_m1_o      (rs1_m1_o),
    .rs2_m1_o      (rs2_m1_o),
    .cls_m1_o      (cls_m1_o),
    .we_m1_o       (we_m1_o),
    .count_instr_o (count_instr_o)
  );

endmodule

//--- hdl/reg_scoreboard.sv
`timescale 1ns/100ps

module reg_scoreboard (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rd_h0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs1_h0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs2_h0_i,
  input  logic [issue_pkg::CLS_W-1:0]       cls_h0_i,
  input  logic                              we_h0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rd_h1_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs1_h1_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs2_h1_i,
  input  logic [issue_pkg::CLS_W-1:0]       cls_h1_i,
  input  logic                              we_h1_i,
  input  logic                              issue_m0_i,
  input  logic                              issue_m1_i,
  input  logic                              wb0_we_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   wb0_rd_i,
  input  logic                              wb1_we_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   wb1_rd_i,
  input  logic                              mu_done_i,
  output logic                              stall_m0_o,
  output logic                              stall_m1_o
);

  logic [issue_pkg::NUM_REGS-1:0] busy;
  logic [issue_pkg::NUM_REGS-1:0] set_vec;
  logic [issue_pkg::NUM_REGS-1:0] clr_vec;
  logic                           mu_busy;
  logic                           mu_issue;

  // busy[0] stays clear, so x0 never stalls
  function automatic logic slot_stall(
    input logic [issue_pkg::NUM_REGS-1:0]  busy_v,
    input logic                            mu_v,
    input logic [issue_pkg::REG_IDX_W-1:0] rd,
    input logic [issue_pkg::REG_IDX_W-1:0] rs1,
    input logic [issue_pkg::REG_IDX_W-1:0] rs2,
    input logic [issue_pkg::CLS_W-1:0]     cls
  );
    logic hazard;
    hazard = busy_v[rd] | busy_v[rs1] | busy_v[rs2];
    return hazard | (mu_v && cls == issue_pkg::CLS_MULDIV);
  endfunction

  assign stall_m0_o = slot_stall(busy, mu_busy, rd_h0_i, rs1_h0_i, rs2_h0_i, cls_h0_i);
  assign stall_m1_o = slot_stall(busy, mu_busy, rd_h1_i, rs1_h1_i, rs2_h1_i, cls_h1_i);

  always_comb begin
    clr_vec = '0;
    if (wb0_we_i) begin
      clr_vec[wb0_rd_i] = 1'b1;
    end
    if (wb1_we_i) begin
      clr_vec[wb1_rd_i] = 1'b1;
    end
  end

  always_comb begin
    set_vec = '0;
    if (issue_m0_i && we_h0_i) begin
      set_vec[rd_h0_i] = 1'b1;
    end
    if (issue_m1_i && we_h1_i) begin
      set_vec[rd_h1_i] = 1'b1;
    end
    set_vec[0] = 1'b0;
  end

  assign mu_issue = (issue_m0_i && cls_h0_i == issue_pkg::CLS_MULDIV) ||
                    (issue_m1_i && cls_h1_i == issue_pkg::CLS_MULDIV);

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      busy    <= '0;
      mu_busy <= 1'b0;
    end else begin
      // a new issue wins over a writeback to the same register
      busy    <= (busy & ~clr_vec) | set_vec;
      mu_busy <= (mu_busy & ~mu_done_i) | mu_issue;
    end
  end

endmodule

//--- hdl/uop_queue.sv
`timescale 1ns/100ps

module uop_queue (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic [1:0]                        fetch_v_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rd_m0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs1_m0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs2_m0_i,
  input  logic [issue_pkg::CLS_W-1:0]       cls_m0_i,
  input  logic                              we_m0_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rd_m1_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs1_m1_i,
  input  logic [issue_pkg::REG_IDX_W-1:0]   rs2_m1_i,
  input  logic [issue_pkg::CLS_W-1:0]       cls_m1_i,
  input  logic                              we_m1_i,
  input  logic [1:0]                        pop_i,
  input  logic                              flush_i,
  output logic                              fetch_rdy_o,
  output logic [1:0]                        head_v_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rd_h0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs1_h0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs2_h0_o,
  output logic [issue_pkg::CLS_W-1:0]       cls_h0_o,
  output logic                              we_h0_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rd_h1_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs1_h1_o,
  output logic [issue_pkg::REG_IDX_W-1:0]   rs2_h1_o,
  output logic [issue_pkg::CLS_W-1:0]       cls_h1_o,
  output logic                              we_h1_o
);

  logic [issue_pkg::REG_IDX_W-1:0] rd_q  [issue_pkg::IQ_DEPTH];
  logic [issue_pkg::REG_IDX_W-1:0] rs1_q [issue_pkg::IQ_DEPTH];
  logic [issue_pkg::REG_IDX_W-1:0] rs2_q [issue_pkg::IQ_DEPTH];
  logic [issue_pkg::CLS_W-1:0]     cls_q [issue_pkg::IQ_DEPTH];
  logic                            we_q  [issue_pkg::IQ_DEPTH];

  logic [issue_pkg::IQ_PTR_W-1:0]  wr_ptr;
  logic [issue_pkg::IQ_PTR_W-1:0]  rd_ptr;
  logic [issue_pkg::IQ_PTR_W:0]    count_q;
  logic [issue_pkg::IQ_PTR_W:0]    count_nxt;
  logic [issue_pkg::IQ_PTR_W-1:0]  wr_ptr_p1;
  logic [issue_pkg::IQ_PTR_W-1:0]  rd_ptr_p1;
  logic [1:0]                      push_n;
  logic [1:0]                      pop_n;

  assign wr_ptr_p1 = wr_ptr + 1'b1;
  assign rd_ptr_p1 = rd_ptr + 1'b1;

  // slot 1 only ever comes with slot 0
  assign push_n = {1'b0, fetch_v_i[0]} + {1'b0, fetch_v_i[1]};
  assign pop_n  = {1'b0, pop_i[0]} + {1'b0, pop_i[1]};

  always_comb begin
    if (flush_i) begin
      count_nxt = '0;
    end else begin
      count_nxt = count_q + push_n - pop_n;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count_q     <= '0;
      fetch_rdy_o <= 1'b1;
    end else begin
      count_q     <= count_nxt;
      // room for a full pair next cycle
      fetch_rdy_o <= (count_nxt <= issue_pkg::IQ_DEPTH - 2);
      if (flush_i) begin
        // writes of this cycle are dropped too
        rd_ptr <= wr_ptr;
      end else begin
        wr_ptr <= wr_ptr + push_n;
        rd_ptr <= rd_ptr + pop_n;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_v_i[0] && !flush_i) begin
      rd_q[wr_ptr]  <= rd_m0_i;
      rs1_q[wr_ptr] <= rs1_m0_i;
      rs2_q[wr_ptr] <= rs2_m0_i;
      cls_q[wr_ptr] <= cls_m0_i;
      we_q[wr_ptr]  <= we_m0_i;
    end
    if (fetch_v_i[1] && !flush_i) begin
      rd_q[wr_ptr_p1]  <= rd_m1_i;
      rs1_q[wr_ptr_p1] <= rs1_m1_i;
      rs2_q[wr_ptr_p1] <= rs2_m1_i;
      cls_q[wr_ptr_p1] <= cls_m1_i;
      we_q[wr_ptr_p1]  <= we_m1_i;
    end
  end

  assign head_v_o[0] = (count_q != '0);
  assign head_v_o[1] = (count_q > 1);

  assign rd_h0_o  = rd_q[rd_ptr];
  assign rs1_h0_o = rs1_q[rd_ptr];
  assign rs2_h0_o = rs2_q[rd_ptr];
  assign cls_h0_o = cls_q[rd_ptr];
  assign we_h0_o  = we_q[rd_ptr];

  assign rd_h1_o  = rd_q[rd_ptr_p1];
  assign rs1_h1_o = rs1_q[rd_ptr_p1];
  assign rs2_h1_o = rs2_q[rd_ptr_p1];
  assign cls_h1_o = cls_q[rd_ptr_p1];
  assign we_h1_o  = we_q[rd_ptr_p1];

endmodule

//--- tb.f
hdl/issue_pkg.sv
hdl/uop_queue.sv
hdl/reg_scoreboard.sv
hdl/issue_ctrl.sv
hdl/issue_unit.sv
testbench/tb_issue_unit.sv

//--- testbench/tb_issue_unit.sv
`timescale 1ns/100ps

module tb_issue_unit;

  // micro-op word is {rd, rs1, rs2, cls, we}
  localparam int UOP_W = 18;

  logic                           clk;
  logic                           resetn = 1'b0;
  logic [1:0]                     fetch_v_i = 2'b00;
  logic [UOP_W-1:0]               in0 = '0;
  logic [UOP_W-1:0]               in1 = '0;
  logic                           wb0_we_i = 1'b0;
  logic [issue_pkg::REG_IDX_W-1:0] wb0_rd_i = '0;
  logic                           wb1_we_i = 1'b0;
  logic [issue_pkg::REG_IDX_W-1:0] wb1_rd_i = '0;
  logic                           mu_done_i = 1'b0;
  logic                           stall_i = 1'b0;
  logic                           flush_i = 1'b0;
  wire  [UOP_W-1:0]               out0;
  wire  [UOP_W-1:0]               out1;
  wire                            fetch_rdy_o;
  wire  [1:0]                     issue_v_o;
  wire  [issue_pkg::CNT_W-1:0]    count_instr_o;

  integer                         seed;
  logic [31:0]                    rnd;
  logic                           fetch_on = 1'b0;
  logic                           rand_on = 1'b0;
  logic                           hold_stall = 1'b0;
  // a clock edge in reset has loaded the DUT registers
  logic                           reset_seen = 1'b0;

  // reference model state
  logic [UOP_W-1:0]               model_q[$];
  logic [issue_pkg::REG_IDX_W-1:0] wb_q[$];
  logic [issue_pkg::NUM_REGS-1:0] busy_m;
  logic [issue_pkg::NUM_REGS-1:0] set_m;
  logic [issue_pkg::NUM_REGS-1:0] wb_clr_prev;
  logic                           mu_m;
  logic                           mu_set;
  logic                           mu_done_prev;
  logic                           mu_pend;
  logic [issue_pkg::CNT_W-1:0]    total;

  issue_unit issue_unit_i (
    .clk           (clk),
    .resetn        (resetn),
    .fetch_v_i     (fetch_v_i),
    .rd_m0_i       (in0[17:13]),
    .rs1_m0_i      (in0[12:8]),
    .rs2_m0_i      (in0[7:3]),
    .cls_m0_i      (in0[2:1]),
    .we_m0_i       (in0[0]),
    .rd_m1_i       (in1[17:13]),
    .rs1_m1_i      (in1[12:8]),
    .rs2_m1_i      (in1[7:3]),
    .cls_m1_i      (in1[2:1]),
    .we_m1_i       (in1[0]),
    .fetch_rdy_o   (fetch_rdy_o),
    .issue_v_o     (issue_v_o),
    .rd_m0_o       (out0[17:13]),
    .rs1_m0_o      (out0[12:8]),
    .rs2_m0_o      (out0[7:3]),
    .cls_m0_o      (out0[2:1]),
    .we_m0_o       (out0[0]),
    .rd_m1_o       (out1[17:13]),
    .rs1_m1_o      (out1[12:8]),
    .rs2_m1_o      (out1[7:3]),
    .cls_m1_o      (out1[2:1]),
    .we_m1_o       (out1[0]),
    .wb0_we_i      (wb0_we_i),
    .wb0_rd_i      (wb0_rd_i),
    .wb1_we_i      (wb1_we_i),
    .wb1_rd_i      (wb1_rd_i),
    .mu_done_i     (mu_done_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .count_instr_o (count_instr_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic bit pair_legal(input logic [UOP_W-1:0] a, input logic [UOP_W-1:0] b);
    logic [4:0] dst;
    dst = a[17:13];
    if (a[2:1] == issue_pkg::CLS_BRANCH) begin
      return 1'b0;
    end
    if (a[2:1] == b[2:1] && a[2:1] != issue_pkg::CLS_ALU) begin
      return 1'b0;
    end
    // a write to x0 creates no dependency
    if (a[0] && dst != 5'd0) begin
      return b[17:13] != dst && b[12:8] != dst && b[7:3] != dst;
    end
    return 1'b1;
  endfunction

  function automatic bit reads_busy(input logic [UOP_W-1:0] u,
                                    input logic [issue_pkg::NUM_REGS-1:0] busy);
    return (u[17:13] != 5'd0 && busy[u[17:13]]) ||
           (u[12:8] != 5'd0 && busy[u[12:8]]) ||
           (u[7:3] != 5'd0 && busy[u[7:3]]);
  endfunction

  // registers 0..7 only, so hazards are frequent
  function automatic logic [UOP_W-1:0] rand_uop();
    logic [31:0] r;
    r = $random(seed);
    return {2'b00, r[2:0], 2'b00, r[5:3], 2'b00, r[8:6], r[10:9], r[13:11] != 3'd0};
  endfunction

  task automatic check_slot(input logic [UOP_W-1:0] got, input int slot);
    logic [UOP_W-1:0] exp;
    assert (model_q.size() != 0)
      else stop_with_failure($sformatf("FAIL %0t: slot %0d issued with nothing queued",
                                       $time, slot));
    exp = model_q.pop_front();
    assert (got == exp)
      else stop_with_failure($sformatf("FAIL %0t: slot %0d issued %h, expected %h",
                                       $time, slot, got, exp));
    assert (!reads_busy(got, busy_m))
      else stop_with_failure($sformatf("FAIL %0t: slot %0d issued on a busy register",
                                       $time, slot));
    assert (!(mu_m && got[2:1] == issue_pkg::CLS_MULDIV))
      else stop_with_failure($sformatf("FAIL %0t: muldiv issued while one is in flight",
                                       $time));
    total = total + 1'b1;
    if (got[0] && got[17:13] != 5'd0) begin
      set_m[got[17:13]] = 1'b1;
      wb_q.push_back(got[17:13]);
    end
    if (got[2:1] == issue_pkg::CLS_MULDIV) begin
      mu_set = 1'b1;
      mu_pend = 1'b1;
    end
  endtask

  assert property (@(posedge clk) ((reset_seen && !resetn) || $rose(resetn)) |->
                   (issue_v_o == 2'b00 && fetch_rdy_o && count_instr_o == '0))
    else stop_with_failure($sformatf("FAIL %0t: outputs not at their reset values", $time));

  assert property (@(posedge clk) disable iff (!resetn) flush_i |=> issue_v_o == 2'b00)
    else stop_with_failure($sformatf("FAIL %0t: issue in the cycle after a flush", $time));

  assert property (@(posedge clk) disable iff (!resetn) stall_i |=> issue_v_o == 2'b00)
    else stop_with_failure($sformatf("FAIL %0t: issue in the cycle after stall_i", $time));

  assert property (@(posedge clk) disable iff (!resetn)
                   issue_v_o[1] |-> (issue_v_o[0] && pair_legal(out0, out1)))
    else stop_with_failure($sformatf("FAIL %0t: illegal dual issue %h / %h",
                                     $time, out0, out1));

  // model update on pre-edge values, then drive the next cycle
  always @(posedge clk) begin
    if (!resetn) begin
      reset_seen <= 1'b1;
      model_q.delete();
      wb_q.delete();
      busy_m = '0;
      wb_clr_prev = '0;
      mu_m = 1'b0;
      mu_done_prev = 1'b0;
      mu_pend = 1'b0;
      total = '0;
    end else begin
      set_m = '0;
      mu_set = 1'b0;
      if (issue_v_o[0]) begin
        check_slot(out0, 0);
      end
      if (issue_v_o[1]) begin
        check_slot(out1, 1);
      end
      assert (count_instr_o == total)
        else stop_with_failure($sformatf("FAIL %0t: count_instr_o %0d, expected %0d",
                                         $time, count_instr_o, total));
      // issue wins over a writeback in the same cycle
      busy_m = (busy_m & ~wb_clr_prev) | set_m;
      mu_m = (mu_m & !mu_done_prev) | mu_set;
      wb_clr_prev = '0;
      if (wb0_we_i) begin
        wb_clr_prev[wb0_rd_i] = 1'b1;
      end
      if (wb1_we_i) begin
        wb_clr_prev[wb1_rd_i] = 1'b1;
      end
      mu_done_prev = mu_done_i;

      // fetch only writes when it saw at most six entries in use
      if (fetch_v_i != 2'b00) begin
        assert (fetch_rdy_o)
          else stop_with_failure($sformatf("FAIL %0t: fetch_rdy_o low with room for a pair",
                                           $time));
      end
      if (flush_i) begin
        model_q.delete();
      end else begin
        if (fetch_v_i[0]) begin
          model_q.push_back(in0);
        end
        if (fetch_v_i[1]) begin
          model_q.push_back(in1);
        end
      end
      assert (model_q.size() <= issue_pkg::IQ_DEPTH)
        else stop_with_failure($sformatf("FAIL %0t: queue overfilled, %0d entries",
                                         $time, model_q.size()));

      rnd = $random(seed);
      stall_i <= hold_stall || (rand_on && rnd[2:0] == 3'd0);
      mu_done_i <= 1'b0;
      if (mu_pend && rnd[3]) begin
        mu_done_i <= 1'b1;
        mu_pend = 1'b0;
      end
      wb0_we_i <= 1'b0;
      wb1_we_i <= 1'b0;
      if (wb_q.size() != 0 && rnd[4]) begin
        wb0_we_i <= 1'b1;
        wb0_rd_i <= wb_q.pop_front();
      end
      if (wb_q.size() != 0 && rnd[5]) begin
        wb1_we_i <= 1'b1;
        wb1_rd_i <= wb_q.pop_front();
      end
      fetch_v_i <= 2'b00;
      if (fetch_on && fetch_rdy_o && fetch_v_i == 2'b00 && rnd[6]) begin
        fetch_v_i <= rnd[7] ? 2'b11 : 2'b01;
        in0 <= rand_uop();
        in1 <= rand_uop();
      end
    end
  end

  initial begin
    int n;
    seed = 32'hc5c6;
    repeat (16) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    fetch_on <= 1'b1;
    rand_on <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      repeat (250 + 60 * i) @(posedge clk);
      flush_i <= 1'b1;
      @(posedge clk);
      flush_i <= 1'b0;
    end

    // fill the queue with issue held off
    fetch_on <= 1'b0;
    rand_on <= 1'b0;
    hold_stall <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    fetch_on <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (fetch_rdy_o && n < 60);
    if (fetch_rdy_o) begin
      stop_with_failure("fetch_rdy_o never fell while the queue filled under a held stall");
    end
    assert (model_q.size() >= issue_pkg::IQ_DEPTH - 1)
      else stop_with_failure($sformatf("FAIL %0t: fetch_rdy_o fell with only %0d entries",
                                       $time, model_q.size()));

    @(posedge clk);
    hold_stall <= 1'b0;
    rand_on <= 1'b1;
    repeat (300) @(posedge clk);

    // drain, every accepted micro-op must come out
    fetch_on <= 1'b0;
    rand_on <= 1'b0;
    repeat (2) @(posedge clk);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (model_q.size() != 0 && n < 500);
    if (model_q.size() != 0) begin
      stop_with_failure("queued micro-ops never issued before the drain timeout");
    end
    repeat (4) @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
